// ==== rtl/gpsCa_cfg.svh ====
`ifndef GPSCA_CFG_SVH
`define GPSCA_CFG_SVH

// Chips in one C/A epoch
`define CA_CODE_LENGTH 1023

// Stages in G1 and in G2
`define CA_LFSR_WIDTH 10

// Flops per key and switch synchronizer
`define KEY_SYNC_STAGES 2

`endif

// ==== rtl/caTypesPkg.sv ====
`include "gpsCa_cfg.svh"

package caTypesPkg;

   // Bit 0 holds stage 1, bit 9 holds stage 10
   typedef logic [`CA_LFSR_WIDTH-1:0] lfsrStateT;

   // Position in epoch, 0 to 1022
   typedef logic [$clog2(`CA_CODE_LENGTH)-1:0] chipIndexT;

   // PRN minus one
   typedef logic [4:0] prnSelT;

   // G2 stage number, 1 to 10
   typedef logic [3:0] tapIndexT;

   // Phase select pair for one satellite
   typedef struct packed {
      tapIndexT tapA;        // First G2 stage
      tapIndexT tapB;        // Second G2 stage
   } tapPairT;

   // Generator outputs seen by the board top
   typedef struct packed {
      logic      chip;       // Current C/A chip
      logic      epoch;      // High at index 0
      chipIndexT chipIndex;  // Chip count in epoch
      lfsrStateT g1State;    // G1 register for LEDs
   } caStatusT;

endpackage

// ==== rtl/boardPkg.sv ====
package boardPkg;

   // Active low segments, gfedcba
   typedef logic [6:0] segT;

   // One hex digit
   typedef logic [3:0] nibbleT;

   // Press tracking per push button
   typedef enum logic {
      keyIdle,               // Released
      keyHeld                // Pressed, pulse already sent
   } keyStateT;

   // Commands into the code generator
   typedef struct packed {
      logic step;            // Advance one chip
      logic restart;         // Reload registers and latch PRN
   } stepCmdT;

endpackage

// ==== rtl/hexDriver.sv ====
`timescale 1ns/100ps

module hexDriver (
   input  boardPkg::nibbleT value,
   output boardPkg::segT    seg        // Active low, gfedcba
);

   always_comb begin
      case (value)
         4'h0: seg = 7'b1000000;
         4'h1: seg = 7'b1111001;
         4'h2: seg = 7'b0100100;
         4'h3: seg = 7'b0110000;
         4'h4: seg = 7'b0011001;
         4'h5: seg = 7'b0010010;
         4'h6: seg = 7'b0000010;
         4'h7: seg = 7'b1111000;
         4'h8: seg = 7'b0000000;
         4'h9: seg = 7'b0010000;
         4'hA: seg = 7'b0001000;
         4'hB: seg = 7'b0000011;        // Lower case b
         4'hC: seg = 7'b1000110;
         4'hD: seg = 7'b0100001;        // Lower case d
         4'hE: seg = 7'b0000110;
         4'hF: seg = 7'b0001110;
         default: seg = 7'b1111111;
      endcase
   end

endmodule

// ==== rtl/prnTapTable.sv ====
`timescale 1ns/100ps

module prnTapTable (
   input  caTypesPkg::prnSelT  prnSel,   // PRN minus one
   output caTypesPkg::tapPairT taps
);

   // G2 phase select pairs, standard table
   always_comb begin
      unique case (prnSel)
         5'd0:  taps = '{tapA: 4'd2, tapB: 4'd6};   // PRN 1
         5'd1:  taps = '{tapA: 4'd3, tapB: 4'd7};
         5'd2:  taps = '{tapA: 4'd4, tapB: 4'd8};
         5'd3:  taps = '{tapA: 4'd5, tapB: 4'd9};
         5'd4:  taps = '{tapA: 4'd1, tapB: 4'd9};   // PRN 5
         5'd5:  taps = '{tapA: 4'd2, tapB: 4'd10};
         5'd6:  taps = '{tapA: 4'd1, tapB: 4'd8};
         5'd7:  taps = '{tapA: 4'd2, tapB: 4'd9};
         5'd8:  taps = '{tapA: 4'd3, tapB: 4'd10};
         5'd9:  taps = '{tapA: 4'd2, tapB: 4'd3};   // PRN 10
         5'd10: taps = '{tapA: 4'd3, tapB: 4'd4};
         5'd11: taps = '{tapA: 4'd5, tapB: 4'd6};
         5'd12: taps = '{tapA: 4'd6, tapB: 4'd7};
         5'd13: taps = '{tapA: 4'd7, tapB: 4'd8};
         5'd14: taps = '{tapA: 4'd8, tapB: 4'd9};   // PRN 15
         5'd15: taps = '{tapA: 4'd9, tapB: 4'd10};
         5'd16: taps = '{tapA: 4'd1, tapB: 4'd4};
         5'd17: taps = '{tapA: 4'd2, tapB: 4'd5};
         5'd18: taps = '{tapA: 4'd3, tapB: 4'd6};
         5'd19: taps = '{tapA: 4'd4, tapB: 4'd7};   // PRN 20
         5'd20: taps = '{tapA: 4'd5, tapB: 4'd8};
         5'd21: taps = '{tapA: 4'd6, tapB: 4'd9};
         5'd22: taps = '{tapA: 4'd1, tapB: 4'd3};
         5'd23: taps = '{tapA: 4'd4, tapB: 4'd6};
         5'd24: taps = '{tapA: 4'd5, tapB: 4'd7};   // PRN 25
         5'd25: taps = '{tapA: 4'd6, tapB: 4'd8};
         5'd26: taps = '{tapA: 4'd7, tapB: 4'd9};
         5'd27: taps = '{tapA: 4'd8, tapB: 4'd10};
         5'd28: taps = '{tapA: 4'd1, tapB: 4'd6};
         5'd29: taps = '{tapA: 4'd2, tapB: 4'd7};   // PRN 30
         5'd30: taps = '{tapA: 4'd3, tapB: 4'd8};
         5'd31: taps = '{tapA: 4'd4, tapB: 4'd9};   // PRN 32
      endcase
   end

endmodule

// ==== rtl/stepControl.sv ====
`timescale 1ns/100ps
`include "gpsCa_cfg.svh"

module stepControl (
   input  logic              CLOCK_50,
   input  logic              arstN,
   input  logic [3:0]        key,        // Raw buttons, active low
   input  logic              freeRun,    // Raw SW[17]
   output logic [3:0]        keyPressed, // For LEDG
   output boardPkg::stepCmdT stepCmd
);

   localparam int syncBits = 5;          // Four keys plus free-run

   logic [syncBits-1:0] syncPipe [`KEY_SYNC_STAGES];
   logic [syncBits-1:0] syncLevels;      // Last synchronizer stage
   logic [3:0]          keySync;         // Synced keys, still active low
   logic                freeRunSync;
   logic [1:0]          heldNow;         // KEY[3] and KEY[0] pressed
   logic [1:0]          pressEdge;       // Idle to held this cycle

   boardPkg::keyStateT  keyState [2];

   // Synchronizer chain for all inputs
   always_ff @(posedge CLOCK_50 or negedge arstN) begin
      if (!arstN) begin
         for (int s = 0; s < `KEY_SYNC_STAGES; s++) begin
            syncPipe[s] <= 5'b01111;      // Keys released, free-run off
         end
      end else begin
         syncPipe[0] <= {freeRun, key};
         for (int s = 1; s < `KEY_SYNC_STAGES; s++) begin
            syncPipe[s] <= syncPipe[s-1];
         end
      end
   end

   assign syncLevels  = syncPipe[`KEY_SYNC_STAGES-1];
   assign keySync     = syncLevels[3:0];
   assign freeRunSync = syncLevels[4];
   assign keyPressed  = ~keySync;
   assign heldNow     = {~keySync[3], ~keySync[0]};

   // Pulse only when leaving idle
   always_comb begin
      for (int i = 0; i < 2; i++) begin
         pressEdge[i] = (keyState[i] == boardPkg::keyIdle) && heldNow[i];
      end
   end

   // One press FSM per used key
   always_ff @(posedge CLOCK_50 or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 2; i++) begin
            keyState[i] <= boardPkg::keyIdle;
         end
      end else begin
         for (int i = 0; i < 2; i++) begin
            case (keyState[i])
               boardPkg::keyIdle: if (heldNow[i]) keyState[i] <= boardPkg::keyHeld;
               boardPkg::keyHeld: if (!heldNow[i]) keyState[i] <= boardPkg::keyIdle;
               default:           keyState[i] <= boardPkg::keyIdle;
            endcase
         end
      end
   end

   // Registered commands, restart drops a same-cycle step
   always_ff @(posedge CLOCK_50 or negedge arstN) begin
      if (!arstN) begin
         stepCmd <= '0;
      end else begin
         stepCmd.restart <= pressEdge[1];
         stepCmd.step    <= (pressEdge[0] | freeRunSync) & ~pressEdge[1];
      end
   end

endmodule

// ==== rtl/caGenerator.sv ====
`timescale 1ns/100ps
`include "gpsCa_cfg.svh"

module caGenerator (
   input  logic                CLOCK_50,
   input  logic                arstN,
   input  boardPkg::stepCmdT   stepCmd,
   input  caTypesPkg::prnSelT  prnIn,    // From SW[4:0]
   input  caTypesPkg::tapPairT taps,     // Lookup of latched PRN
   output caTypesPkg::prnSelT  prnSel,   // Latched PRN to tap table
   output caTypesPkg::caStatusT status
);

   caTypesPkg::lfsrStateT g1;            // Bit 0 is stage 1
   caTypesPkg::lfsrStateT g2;
   caTypesPkg::chipIndexT chipIndex;
   caTypesPkg::prnSelT    prnLatched;

   logic g1Fb;                           // Taps 3, 10
   logic g2Fb;                           // Taps 2, 3, 6, 8, 9, 10
   logic g2PhaseA;
   logic g2PhaseB;
   logic lastChip;                       // Index at 1022

   assign g1Fb = g1[2] ^ g1[9];
   assign g2Fb = g2[1] ^ g2[2] ^ g2[5] ^ g2[7] ^ g2[8] ^ g2[9];

   // Stage numbers are 1-based
   assign g2PhaseA = g2[taps.tapA - 4'd1];
   assign g2PhaseB = g2[taps.tapB - 4'd1];

   assign lastChip = (chipIndex == caTypesPkg::chipIndexT'(`CA_CODE_LENGTH - 1));

   always_ff @(posedge CLOCK_50 or negedge arstN) begin
      if (!arstN) begin
         g1         <= '1;
         g2         <= '1;
         chipIndex  <= '0;
         prnLatched <= '0;                // PRN 1
      end else if (stepCmd.restart) begin // Restart wins over step
         g1         <= '1;
         g2         <= '1;
         chipIndex  <= '0;
         prnLatched <= prnIn;
      end else if (stepCmd.step) begin
         g1        <= {g1[8:0], g1Fb};    // Shift toward stage 10
         g2        <= {g2[8:0], g2Fb};
         chipIndex <= lastChip ? '0 : chipIndex + 1'b1;
      end
   end

   assign prnSel = prnLatched;

   // Status for LEDs and displays
   assign status.chip      = g1[9] ^ g2PhaseA ^ g2PhaseB;
   assign status.epoch     = (chipIndex == '0);
   assign status.chipIndex = chipIndex;
   assign status.g1State   = g1;

endmodule

// ==== rtl/gpsCaTop.sv ====
`timescale 1ns/100ps

module gpsCaTop (
   input  logic          CLOCK_50,
   input  logic          arstN,
   input  logic [3:0]    KEY,          // Active low buttons
   input  logic [17:0]   SW,
   output boardPkg::segT HEX0,
   output boardPkg::segT HEX1,
   output boardPkg::segT HEX2,
   output boardPkg::segT HEX3,
   output boardPkg::segT HEX4,
   output boardPkg::segT HEX5,
   output boardPkg::segT HEX6,
   output boardPkg::segT HEX7,
   output logic [8:0]    LEDG,
   output logic [17:0]   LEDR
);

   boardPkg::stepCmdT    stepCmd;
   caTypesPkg::prnSelT   prnSel;
   caTypesPkg::tapPairT  taps;
   caTypesPkg::caStatusT status;
   logic [3:0]           keyPressed;

   stepControl stepControl_i (
      .CLOCK_50  (CLOCK_50),
      .arstN     (arstN),
      .key       (KEY),
      .freeRun   (SW[17]),
      .keyPressed(keyPressed),
      .stepCmd   (stepCmd)
   );

   prnTapTable prnTapTable_i (
      .prnSel(prnSel),
      .taps  (taps)
   );

   caGenerator caGenerator_i (
      .CLOCK_50(CLOCK_50),
      .arstN   (arstN),
      .stepCmd (stepCmd),
      .prnIn   (SW[4:0]),
      .taps    (taps),
      .prnSel  (prnSel),
      .status  (status)
   );

   // Chip index in hex
   hexDriver chipDigit2_i (.value({2'b00, status.chipIndex[9:8]}), .seg(HEX2));
   hexDriver chipDigit1_i (.value(status.chipIndex[7:4]), .seg(HEX1));
   hexDriver chipDigit0_i (.value(status.chipIndex[3:0]), .seg(HEX0));

   // Live switch field, not the latched PRN
   hexDriver prnDigit1_i (.value({3'b000, SW[4]}), .seg(HEX5));
   hexDriver prnDigit0_i (.value(SW[3:0]), .seg(HEX4));

   assign HEX3 = 7'h7F;                 // Blank
   assign HEX6 = 7'h7F;
   assign HEX7 = 7'h7F;

   assign LEDR[17:8] = status.g1State;
   assign LEDR[7]    = 1'b0;
   assign LEDR[6]    = status.chip;
   assign LEDR[5:0]  = '0;

   assign LEDG[8]   = status.epoch;     // Epoch mark
   assign LEDG[7:4] = '0;
   assign LEDG[3:0] = keyPressed;

endmodule

// ==== sim/gpsCaTop_properties.sv ====
`timescale 1ns/100ps
`include "gpsCa_cfg.svh"

module caGeneratorProps (
   input logic                  CLOCK_50,
   input logic                  arstN,
   input boardPkg::stepCmdT     stepCmd,
   input caTypesPkg::chipIndexT chipIndex,
   input caTypesPkg::lfsrStateT g1,
   input caTypesPkg::caStatusT  status
);

   // Index wraps before the code length
   indexInRange: assert property (@(posedge CLOCK_50) disable iff (!arstN)
      int'(chipIndex) < `CA_CODE_LENGTH)
      else $error("Chip index %0d beyond the epoch", chipIndex);

   // All zeros would lock G1
   g1NonZero: assert property (@(posedge CLOCK_50) disable iff (!arstN)
      g1 != '0)
      else $error("G1 register reached all zeros");

   // Epoch set by restart or wrap, kept while idle
   epochMatch: assert property (@(posedge CLOCK_50) disable iff (!arstN)
      status.epoch == ($past(stepCmd.restart) ||
                       ($past(stepCmd.step)
                        ? $past(chipIndex) == caTypesPkg::chipIndexT'(`CA_CODE_LENGTH - 1)
                        : $past(status.epoch))))
      else $error("Epoch flag disagrees with index %0d", chipIndex);

   // Restart wins over any step
   restartClears: assert property (@(posedge CLOCK_50) disable iff (!arstN)
      stepCmd.restart |=> chipIndex == '0)
      else $error("Index %0d after restart", chipIndex);

endmodule

bind caGenerator caGeneratorProps caGeneratorProps_i (
   .CLOCK_50 (CLOCK_50),
   .arstN    (arstN),
   .stepCmd  (stepCmd),
   .chipIndex(chipIndex),
   .g1       (g1),
   .status   (status)
);

// ==== sim/gpsCaTopTb.sv ====
`timescale 1ns/100ps
`include "gpsCa_cfg.svh"

module gpsCaTopTb;

   localparam int settle     = 8;             // Cycles after each action
   localparam int maxHold    = 16;            // Longest random key hold
   localparam int longHold   = 48;
   localparam int pressCost  = maxHold + settle;
   localparam int prnRounds  = 4;             // Random PRNs in manual test
   localparam int runRounds  = 4;             // Free-run bursts
   localparam int maxRun     = 3000;

   // Worst case cycles per test
   localparam int resetCost   = 4 + settle;
   localparam int manualCost  = 11 * pressCost + longHold + prnRounds * 41 * pressCost;
   localparam int latchCost   = 60 * pressCost;
   localparam int freeRunCost = runRounds * (maxRun + 3 * pressCost);
   localparam int activeCost  = 500 + 12 * pressCost;
   localparam int watchdogCycles =
      2 * (resetCost + manualCost + latchCost + freeRunCost + activeCost);

   // Independent copy of the G2 phase select table, index is PRN minus one
   localparam int tapA [32] = '{2, 3, 4, 5, 1, 2, 1, 2, 3, 2, 3, 5, 6, 7, 8, 9,
                                1, 2, 3, 4, 5, 6, 1, 4, 5, 6, 7, 8, 1, 2, 3, 4};
   localparam int tapB [32] = '{6, 7, 8, 9, 9, 10, 8, 9, 10, 3, 4, 6, 7, 8, 9, 10,
                                4, 5, 6, 7, 8, 9, 3, 6, 7, 8, 9, 10, 6, 7, 8, 9};

   // Active low gfedcba digits 0 to F
   localparam boardPkg::segT segTable [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12,
                                               7'h02, 7'h78, 7'h00, 7'h10, 7'h08, 7'h03,
                                               7'h46, 7'h21, 7'h06, 7'h0E};
   localparam boardPkg::segT segBlank = 7'h7F;

   logic          CLOCK_50;
   logic          arstN;
   logic [3:0]    KEY;
   logic [17:0]   SW;
   boardPkg::segT HEX0;
   boardPkg::segT HEX1;
   boardPkg::segT HEX2;
   boardPkg::segT HEX3;
   boardPkg::segT HEX4;
   boardPkg::segT HEX5;
   boardPkg::segT HEX6;
   boardPkg::segT HEX7;
   logic [8:0]    LEDG;
   logic [17:0]   LEDR;

   integer seed          = 38;
   int     checkCount    = 0;
   int     errorCount    = 0;
   int     testCount     = 0;
   int     testCheckBase = 0;
   int     testErrorBase = 0;

   logic                  modelChip;           // Model outputs, last evaluation
   caTypesPkg::lfsrStateT modelG1;
   caTypesPkg::chipIndexT modelIndex;

   gpsCaTop gpsCaTop_i (.*);

   initial begin
      CLOCK_50 = 1'b0;
      forever #4 CLOCK_50 = ~CLOCK_50;         // 125 MHz in sim
   end

   function automatic int randRange(input int lo, input int hi);
      return lo + int'({$random(seed)} % (hi - lo + 1));
   endfunction

   // G1/G2 after a given number of steps from restart
   task automatic modelAt(input int steps, input caTypesPkg::prnSelT prn);
      bit [10:1] g1;                           // Index is stage number
      bit [10:1] g2;
      bit        fb1;
      bit        fb2;
      g1 = '1;
      g2 = '1;
      for (int n = 0; n < steps; n++) begin
         fb1 = g1[3] ^ g1[10];
         fb2 = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];
         g1  = {g1[9:1], fb1};                 // Stage i moves to i+1
         g2  = {g2[9:1], fb2};
      end
      modelChip  = g1[10] ^ g2[tapA[prn]] ^ g2[tapB[prn]];
      modelG1    = g1;                         // Stage 1 lands in bit 0
      modelIndex = caTypesPkg::chipIndexT'(steps % `CA_CODE_LENGTH);
   endtask

   task automatic compareChip(input string name, input logic expected, input logic actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("ERROR %s: expected %0b, actual %0b", name, expected, actual);
      end
   endtask

   task automatic compareIndex(input string name, input caTypesPkg::chipIndexT expected,
                               input caTypesPkg::chipIndexT actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic compareLfsr(input string name, input caTypesPkg::lfsrStateT expected,
                              input caTypesPkg::lfsrStateT actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("ERROR %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic compareSeg(input string name, input boardPkg::segT expected,
                             input boardPkg::segT actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("ERROR %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic compareKeys(input string name, input logic [3:0] expected,
                              input logic [3:0] actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("ERROR %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic decodeDigit(input boardPkg::segT seg, output boardPkg::nibbleT value,
                              output bit ok);
      value = '0;
      ok    = 1'b0;
      for (int d = 0; d < 16; d++) begin
         if (seg === segTable[d]) begin
            value = boardPkg::nibbleT'(d);
            ok    = 1'b1;
         end
      end
   endtask

   // Chip index as shown on HEX2..HEX0
   task automatic readIndex(output caTypesPkg::chipIndexT idx);
      boardPkg::nibbleT d2;
      boardPkg::nibbleT d1;
      boardPkg::nibbleT d0;
      bit               ok2;
      bit               ok1;
      bit               ok0;
      decodeDigit(HEX2, d2, ok2);
      decodeDigit(HEX1, d1, ok1);
      decodeDigit(HEX0, d0, ok0);
      if (!(ok2 && ok1 && ok0)) begin
         errorCount++;
         $display("Index display shows a pattern that is not a hex digit");
      end
      idx = caTypesPkg::chipIndexT'({d2[1:0], d1, d0});
   endtask

   task automatic checkState(input string name, input int steps, input caTypesPkg::prnSelT prn);
      caTypesPkg::chipIndexT shown;
      modelAt(steps, prn);
      readIndex(shown);
      compareIndex({name, " index"}, modelIndex, shown);
      compareChip({name, " chip"}, modelChip, LEDR[6]);
      compareLfsr({name, " g1"}, modelG1, LEDR[17:8]);
      compareChip({name, " epoch"}, modelIndex == '0, LEDG[8]);
   endtask

   task automatic checkPrnDisplay(input string name);
      compareSeg({name, " HEX4"}, segTable[SW[3:0]], HEX4);
      compareSeg({name, " HEX5"}, segTable[{3'b000, SW[4]}], HEX5);
   endtask

   task automatic finishTest(input string name);
      testCount++;
      $display("%s: %0d checks, %0d errors", name, checkCount - testCheckBase,
               errorCount - testErrorBase);
      testCheckBase = checkCount;
      testErrorBase = errorCount;
   endtask

   task automatic waitCycles(input int n);
      repeat (n) @(negedge CLOCK_50);
   endtask

   // Keys are active low
   task automatic pressKey(input int which, input int hold);
      KEY[which] = 1'b0;
      waitCycles(hold);
      KEY[which] = 1'b1;
      waitCycles(settle);
   endtask

   task automatic restartWith(input caTypesPkg::prnSelT prn);
      SW[4:0] = prn;
      pressKey(3, randRange(1, 4));
   endtask

   task automatic testReset();
      caTypesPkg::chipIndexT shown;
      readIndex(shown);
      compareIndex("reset index", '0, shown);
      compareLfsr("reset g1", '1, LEDR[17:8]);
      compareChip("reset epoch", 1'b1, LEDG[8]);
      modelAt(0, 5'd0);                        // PRN 1 after reset
      compareChip("reset chip", modelChip, LEDR[6]);
      compareSeg("reset HEX3", segBlank, HEX3);
      compareSeg("reset HEX6", segBlank, HEX6);
      compareSeg("reset HEX7", segBlank, HEX7);
      checkPrnDisplay("reset");
      compareKeys("reset key LEDs", 4'b0000, LEDG[3:0]);
      compareChip("reset unused LEDG", 1'b0, |LEDG[7:4]);
      compareChip("reset unused LEDR", 1'b0, |{LEDR[7], LEDR[5:0]});
      finishTest("reset state");
   endtask

   task automatic testManual();
      logic [9:0]         knownChips;
      caTypesPkg::prnSelT prn;
      int                 presses;
      knownChips = 10'b1100100000;             // First PRN 1 chips
      restartWith(5'd0);
      for (int n = 0; n < 10; n++) begin
         compareChip("prn1 known chip", knownChips[9-n], LEDR[6]);
         pressKey(0, randRange(1, maxHold));
      end
      checkState("prn1 after ten", 10, 5'd0);
      pressKey(0, longHold);                   // Still a single step
      checkState("long hold", 11, 5'd0);
      for (int r = 0; r < prnRounds; r++) begin
         prn = caTypesPkg::prnSelT'(randRange(0, 31));
         restartWith(prn);
         presses = randRange(20, 40);
         for (int p = 1; p <= presses; p++) begin
            pressKey(0, randRange(1, maxHold));
            checkState("manual step", p, prn);
         end
      end
      finishTest("manual stepping");
   endtask

   task automatic testLatch();
      caTypesPkg::prnSelT prn;
      caTypesPkg::prnSelT newPrn;
      int                 steps;
      int                 presses;
      prn   = caTypesPkg::prnSelT'(randRange(0, 31));
      steps = 0;
      restartWith(prn);
      presses = randRange(5, 15);
      for (int p = 0; p < presses; p++) begin
         pressKey(0, randRange(1, maxHold));
         steps++;
         checkState("before switch", steps, prn);
      end
      newPrn  = prn + caTypesPkg::prnSelT'(randRange(1, 31));   // Always differs
      SW[4:0] = newPrn;
      waitCycles(settle);
      checkPrnDisplay("after switch");
      checkState("switch only", steps, prn);
      presses = randRange(5, 15);
      for (int p = 0; p < presses; p++) begin
         pressKey(0, randRange(1, maxHold));
         steps++;
         checkState("old prn kept", steps, prn);
      end
      pressKey(3, randRange(1, 4));
      checkState("new prn start", 0, newPrn);
      for (int p = 1; p <= 10; p++) begin
         pressKey(0, randRange(1, maxHold));
         checkState("new prn", p, newPrn);
      end
      finishTest("prn latching");
   endtask

   task automatic testFreeRun();
      caTypesPkg::prnSelT    prn;
      caTypesPkg::chipIndexT shown;
      int                    runLength;
      int                    drift;
      for (int r = 0; r < runRounds; r++) begin
         prn = caTypesPkg::prnSelT'(randRange(0, 31));
         restartWith(prn);
         runLength = randRange(1100, maxRun);
         SW[17]    = 1'b1;
         waitCycles(runLength);
         SW[17]    = 1'b0;
         waitCycles(settle);
         readIndex(shown);
         // Step count should match run length, modulo the epoch
         drift = (int'(shown) - runLength % `CA_CODE_LENGTH + `CA_CODE_LENGTH)
                 % `CA_CODE_LENGTH;
         checkCount++;
         if (drift > 3 && drift < `CA_CODE_LENGTH - 3) begin
            errorCount++;
            $display("Free-run of %0d cycles stopped at index %0d, far from the run length",
                     runLength, shown);
         end
         checkState("free-run", int'(shown), prn);
      end
      finishTest("free-run and wrap");
   endtask

   task automatic testRestartActive();
      caTypesPkg::prnSelT newPrn;
      restartWith(caTypesPkg::prnSelT'(randRange(0, 31)));
      newPrn  = caTypesPkg::prnSelT'(randRange(0, 31));
      SW[4:0] = newPrn;
      SW[17]  = 1'b1;
      waitCycles(randRange(100, 500));
      KEY[3]  = 1'b0;                          // Restart while free-run still high
      waitCycles(1);
      SW[17]  = 1'b0;
      waitCycles(randRange(1, 4));
      KEY[3]  = 1'b1;
      waitCycles(settle);
      checkState("restart in free-run", 0, newPrn);
      for (int p = 1; p <= 3; p++) begin
         pressKey(0, randRange(1, maxHold));
         checkState("after free-run restart", p, newPrn);
      end
      newPrn  = caTypesPkg::prnSelT'(randRange(0, 31));
      SW[4:0] = newPrn;
      KEY[0]  = 1'b0;                          // Step key stays down
      waitCycles(settle);
      compareKeys("held key LEDs", 4'b0001, LEDG[3:0]);
      pressKey(3, randRange(1, 4));
      checkState("restart while held", 0, newPrn);
      KEY[0] = 1'b1;
      waitCycles(settle);
      compareKeys("released key LEDs", 4'b0000, LEDG[3:0]);
      checkState("release after restart", 0, newPrn);
      pressKey(0, randRange(1, maxHold));
      checkState("step after held restart", 1, newPrn);
      finishTest("restart during activity");
   endtask

   initial begin
      KEY     = 4'hF;
      SW      = '0;
      arstN   = 1'b0;
      SW[4:0] = caTypesPkg::prnSelT'(randRange(0, 31));
      repeat (4) @(negedge CLOCK_50);
      arstN = 1'b1;
      waitCycles(settle);
      testReset();
      testManual();
      testLatch();
      testFreeRun();
      testRestartActive();
      $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
      if (errorCount == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // Ends a run that stalls
   initial begin
      repeat (watchdogCycles) @(posedge CLOCK_50);
      $display("Watchdog expired after %0d cycles before the tests finished", watchdogCycles);
      $display("test failed");
      $finish;
   end

endmodule

// ==== gpsCaTop.f ====
+incdir+rtl
rtl/caTypesPkg.sv
rtl/boardPkg.sv
rtl/hexDriver.sv
rtl/prnTapTable.sv
rtl/stepControl.sv
rtl/caGenerator.sv
rtl/gpsCaTop.sv
sim/gpsCaTop_properties.sv
sim/gpsCaTopTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the GPS C/A testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f gpsCaTop.f --top-module gpsCaTopTb -o gpsCaTopSim

simOut=$(./obj_dir/gpsCaTopSim 2>&1) || { printf '%s\n' "$simOut"; exit 1; }
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -qx "test passed"; then
   exit 0
fi
exit 1
